// ==== include/frame_reader_defs.svh ====
`ifndef FRAME_READER_DEFS_SVH
`define FRAME_READER_DEFS_SVH

// --------------------
// AXI bus widths
`define FR_ADDR_W 32
`define FR_DATA_W 32

// Beats per incrementing burst
`define FR_BURST_LEN 4

// --------------------
// Frame geometry in 8-bit pixels
`define FR_IMG_WIDTH 16
`define FR_IMG_HEIGHT 4

// Local beat buffer and status counter
`define FR_FIFO_DEPTH 8
`define FR_CNT_W 16

`endif

// ==== source/frame_reader_pkg.sv ====
`include "frame_reader_defs.svh"

package frame_reader_pkg;

	// Byte address and one bus beat
	typedef logic [`FR_ADDR_W-1:0] addr_t;
	typedef logic [`FR_DATA_W-1:0] data_t;

	// Remaining pixels in a line, remaining lines in a frame
	typedef logic [11:0] col_t;
	typedef logic [11:0] row_t;

	// Completed frames
	typedef logic [`FR_CNT_W-1:0] frame_cnt_t;

	// Register index: 0 control, 1 base address, 2 status
	typedef logic [1:0] reg_sel_t;

	// Burst reader FSM
	typedef enum logic [1:0] {
		RD_IDLE,
		RD_ADDR,
		RD_DATA
	} rd_state_t;

endpackage

// ==== source/rd_ctrl_if.sv ====
`timescale 1ns/1ps

interface rd_ctrl_if;
	import frame_reader_pkg::*;

	// Configuration from the register block
	addr_t base_addr;
	logic  enable;

	// Frame position from the tracker
	logic  frame_first;
	logic  frame_end;

	// Error beat seen on the R channel
	logic  resp_err;

	modport regs    (output base_addr, output enable, input frame_end, input resp_err);

	modport reader  (input base_addr, input enable, input frame_first, output resp_err);

	modport tracker (output frame_first, output frame_end);

endinterface

// ==== source/reader_regs.sv ====
`timescale 1ns/1ps
`include "frame_reader_defs.svh"

module reader_regs (
	input  logic                       M_AXI_ACLK,
	input  logic                       M_AXI_ARESETN,
	input  logic                       cfg_we,
	input  frame_reader_pkg::reg_sel_t cfg_sel,
	input  frame_reader_pkg::data_t    cfg_wdata,
	output frame_reader_pkg::data_t    cfg_rdata,
	rd_ctrl_if.regs                    ctrl
);
	import frame_reader_pkg::*;

	localparam reg_sel_t REG_CTRL   = 2'd0;
	localparam reg_sel_t REG_BASE   = 2'd1;
	localparam reg_sel_t REG_STATUS = 2'd2;

	frame_cnt_t frame_cnt;
	logic       err_flag;
	data_t      status_word;

	// --------------------
	// Configuration and status registers
	always_ff @(posedge M_AXI_ACLK) begin
		if (!M_AXI_ARESETN) begin
			ctrl.enable    <= 1'b0;
			ctrl.base_addr <= '0;
			frame_cnt      <= '0;
			err_flag       <= 1'b0;
		end else begin
			if (cfg_we && cfg_sel == REG_CTRL)
				ctrl.enable <= cfg_wdata[0];
			// Reader picks this up only at the start of a frame
			if (cfg_we && cfg_sel == REG_BASE)
				ctrl.base_addr <= addr_t'(cfg_wdata);
			if (ctrl.frame_end)
				frame_cnt <= frame_cnt + 1'b1;
			// A new error beat wins over a clearing write
			if (ctrl.resp_err)
				err_flag <= 1'b1;
			else if (cfg_we && cfg_sel == REG_STATUS)
				err_flag <= 1'b0;
		end
	end

	// Count in the low half, sticky error in the top bit
	always_comb begin
		status_word                 = '0;
		status_word[`FR_CNT_W-1:0]  = frame_cnt;
		status_word[`FR_DATA_W-1]   = err_flag;
	end

	always_comb begin
		case (cfg_sel)
			REG_CTRL:   cfg_rdata = data_t'(ctrl.enable);
			REG_BASE:   cfg_rdata = data_t'(ctrl.base_addr);
			REG_STATUS: cfg_rdata = status_word;
			default:    cfg_rdata = '0;
		endcase
	end

endmodule

// ==== source/burst_reader.sv ====
`timescale 1ns/1ps
`include "frame_reader_defs.svh"

module burst_reader (
	input  logic                    M_AXI_ACLK,
	input  logic                    M_AXI_ARESETN,
	output frame_reader_pkg::addr_t ARADDR,
	output logic [7:0]              ARLEN,
	output logic [2:0]              ARSIZE,
	output logic [1:0]              ARBURST,
	output logic                    ARVALID,
	input  logic                    ARREADY,
	input  frame_reader_pkg::data_t RDATA,
	input  logic [1:0]              RRESP,
	input  logic                    RLAST,
	input  logic                    RVALID,
	input  logic                    fifo_full,
	output logic                    RREADY,
	output logic                    beat_accept,
	rd_ctrl_if.reader               ctrl
);
	import frame_reader_pkg::*;

	// Address step between consecutive bursts
	localparam addr_t BURST_BYTES = addr_t'(`FR_BURST_LEN * `FR_DATA_W / 8);

	rd_state_t state;
	addr_t     araddr_q;
	logic      start_burst;

	// --------------------
	// Fixed burst shape
	assign ARLEN   = 8'(`FR_BURST_LEN - 1);
	assign ARSIZE  = 3'($clog2(`FR_DATA_W / 8));
	assign ARBURST = 2'b01;
	assign ARADDR  = araddr_q;
	assign ARVALID = (state == RD_ADDR);

	// Room in the FIFO is the only R channel throttle
	assign RREADY      = !fifo_full;
	assign beat_accept = RVALID && RREADY;

	// SLVERR and DECERR both carry bit 1
	assign ctrl.resp_err = beat_accept && RRESP[1];

	// A new frame also needs the enable bit
	assign start_burst = RREADY && (!ctrl.frame_first || ctrl.enable);

	// --------------------
	// One burst in flight
	always_ff @(posedge M_AXI_ACLK) begin
		if (!M_AXI_ARESETN) begin
			state    <= RD_IDLE;
			araddr_q <= '0;
		end else begin
			case (state)
				RD_IDLE: begin
					if (start_burst) begin
						state <= RD_ADDR;
						if (ctrl.frame_first)
							araddr_q <= ctrl.base_addr;
						else
							araddr_q <= araddr_q + BURST_BYTES;
					end
				end
				RD_ADDR: begin
					if (ARREADY)
						state <= RD_DATA;
				end
				RD_DATA: begin
					// Slave decides when the burst is over
					if (beat_accept && RLAST)
						state <= RD_IDLE;
				end
				default: state <= RD_IDLE;
			endcase
		end
	end

endmodule

// ==== source/frame_tracker.sv ====
`timescale 1ns/1ps
`include "frame_reader_defs.svh"

module frame_tracker (
	input  logic        M_AXI_ACLK,
	input  logic        M_AXI_ARESETN,
	input  logic        beat_accept,
	output logic        beat_sof,
	output logic        beat_eol,
	rd_ctrl_if.tracker  ctrl
);
	import frame_reader_pkg::*;

	localparam col_t COL_INIT = col_t'(`FR_IMG_WIDTH);
	localparam row_t ROW_INIT = row_t'(`FR_IMG_HEIGHT);
	localparam col_t COL_STEP = col_t'(`FR_DATA_W / 8);

	// Both counts include the beat that is next to arrive
	col_t col_left;
	row_t row_left;
	logic last_line;

	// --------------------
	// Markers for the beat on the bus
	assign ctrl.frame_first = (col_left == COL_INIT) && (row_left == ROW_INIT);
	assign beat_sof         = ctrl.frame_first;
	assign beat_eol         = (col_left == COL_STEP);
	assign last_line        = (row_left == row_t'(1));
	assign ctrl.frame_end   = beat_accept && beat_eol && last_line;

	always_ff @(posedge M_AXI_ACLK) begin
		if (!M_AXI_ARESETN) begin
			col_left <= COL_INIT;
			row_left <= ROW_INIT;
		end else if (beat_accept) begin
			if (beat_eol) begin
				col_left <= COL_INIT;
				// Wrap to a fresh frame after the final line
				if (last_line)
					row_left <= ROW_INIT;
				else
					row_left <= row_left - 1'b1;
			end else begin
				col_left <= col_left - COL_STEP;
			end
		end
	end

endmodule

// ==== source/beat_fifo.sv ====
`timescale 1ns/1ps
`include "frame_reader_defs.svh"

module beat_fifo (
	input  logic                    M_AXI_ACLK,
	input  logic                    M_AXI_ARESETN,
	input  logic                    push,
	input  frame_reader_pkg::data_t push_data,
	input  logic                    push_sof,
	input  logic                    push_eol,
	output logic                    full,
	input  logic                    pop,
	output logic                    head_valid,
	output frame_reader_pkg::data_t head_data,
	output logic                    head_sof,
	output logic                    head_eol
);
	import frame_reader_pkg::*;

	localparam int DEPTH = `FR_FIFO_DEPTH;
	localparam int PTR_W = $clog2(DEPTH);

	data_t            mem_data [DEPTH];
	logic             mem_sof  [DEPTH];
	logic             mem_eol  [DEPTH];
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [PTR_W:0]   count;
	logic             do_push;
	logic             do_pop;

	assign full       = (count == (PTR_W+1)'(DEPTH));
	assign head_valid = (count != '0);
	assign do_push    = push && !full;
	assign do_pop     = pop && head_valid;

	// Head is read straight from storage
	assign head_data = mem_data[rd_ptr];
	assign head_sof  = mem_sof[rd_ptr];
	assign head_eol  = mem_eol[rd_ptr];

	always_ff @(posedge M_AXI_ACLK) begin
		if (do_push) begin
			mem_data[wr_ptr] <= push_data;
			mem_sof[wr_ptr]  <= push_sof;
			mem_eol[wr_ptr]  <= push_eol;
		end
	end

	// Pointers wrap on their own, depth is a power of two
	always_ff @(posedge M_AXI_ACLK) begin
		if (!M_AXI_ARESETN) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (do_push)
				wr_ptr <= wr_ptr + 1'b1;
			if (do_pop)
				rd_ptr <= rd_ptr + 1'b1;
			count <= count + (PTR_W+1)'(do_push) - (PTR_W+1)'(do_pop);
		end
	end

endmodule

// ==== source/frame_reader_top.sv ====
`timescale 1ns/1ps

module frame_reader_top (
	input  logic                       M_AXI_ACLK,
	input  logic                       M_AXI_ARESETN,
	// Register port
	input  logic                       cfg_we,
	input  frame_reader_pkg::reg_sel_t cfg_sel,
	input  frame_reader_pkg::data_t    cfg_wdata,
	output frame_reader_pkg::data_t    cfg_rdata,
	// Pixel stream
	output logic                       out_valid,
	output frame_reader_pkg::data_t    out_data,
	output logic                       out_sof,
	output logic                       out_eol,
	input  logic                       out_pop,
	// AXI read address channel
	output logic                       M_AXI_ARID,
	output frame_reader_pkg::addr_t    M_AXI_ARADDR,
	output logic [7:0]                 M_AXI_ARLEN,
	output logic [2:0]                 M_AXI_ARSIZE,
	output logic [1:0]                 M_AXI_ARBURST,
	output logic                       M_AXI_ARLOCK,
	output logic [3:0]                 M_AXI_ARCACHE,
	output logic [2:0]                 M_AXI_ARPROT,
	output logic [3:0]                 M_AXI_ARQOS,
	output logic                       M_AXI_ARVALID,
	input  logic                       M_AXI_ARREADY,
	// AXI read data channel
	input  logic                       M_AXI_RID,
	input  frame_reader_pkg::data_t    M_AXI_RDATA,
	input  logic [1:0]                 M_AXI_RRESP,
	input  logic                       M_AXI_RLAST,
	input  logic                       M_AXI_RVALID,
	output logic                       M_AXI_RREADY
);
	import frame_reader_pkg::*;

	logic fifo_full;
	logic beat_accept;
	logic beat_sof;
	logic beat_eol;

	rd_ctrl_if ctrl ();

	// --------------------
	// Single ID, normal unprivileged access
	assign M_AXI_ARID    = 1'b0;
	assign M_AXI_ARLOCK  = 1'b0;
	assign M_AXI_ARCACHE = 4'b0000;
	assign M_AXI_ARPROT  = 3'b000;
	assign M_AXI_ARQOS   = 4'b0000;

	reader_regs i_regs (
		.M_AXI_ACLK    (M_AXI_ACLK),
		.M_AXI_ARESETN (M_AXI_ARESETN),
		.cfg_we        (cfg_we),
		.cfg_sel       (cfg_sel),
		.cfg_wdata     (cfg_wdata),
		.cfg_rdata     (cfg_rdata),
		.ctrl          (ctrl.regs)
	);

	burst_reader i_reader (
		.M_AXI_ACLK    (M_AXI_ACLK),
		.M_AXI_ARESETN (M_AXI_ARESETN),
		.ARADDR        (M_AXI_ARADDR),
		.ARLEN         (M_AXI_ARLEN),
		.ARSIZE        (M_AXI_ARSIZE),
		.ARBURST       (M_AXI_ARBURST),
		.ARVALID       (M_AXI_ARVALID),
		.ARREADY       (M_AXI_ARREADY),
		.RDATA         (M_AXI_RDATA),
		.RRESP         (M_AXI_RRESP),
		.RLAST         (M_AXI_RLAST),
		.RVALID        (M_AXI_RVALID),
		.fifo_full     (fifo_full),
		.RREADY        (M_AXI_RREADY),
		.beat_accept   (beat_accept),
		.ctrl          (ctrl.reader)
	);

	frame_tracker i_tracker (
		.M_AXI_ACLK    (M_AXI_ACLK),
		.M_AXI_ARESETN (M_AXI_ARESETN),
		.beat_accept   (beat_accept),
		.beat_sof      (beat_sof),
		.beat_eol      (beat_eol),
		.ctrl          (ctrl.tracker)
	);

	// Accepted beats go in the same cycle, with their markers
	beat_fifo i_fifo (
		.M_AXI_ACLK    (M_AXI_ACLK),
		.M_AXI_ARESETN (M_AXI_ARESETN),
		.push          (beat_accept),
		.push_data     (M_AXI_RDATA),
		.push_sof      (beat_sof),
		.push_eol      (beat_eol),
		.full          (fifo_full),
		.pop           (out_pop),
		.head_valid    (out_valid),
		.head_data     (out_data),
		.head_sof      (out_sof),
		.head_eol      (out_eol)
	);

endmodule

// ==== test/axi_rd_mem_model.sv ====
`timescale 1ns/1ps
`include "frame_reader_defs.svh"

module axi_rd_mem_model (
	input  logic                    M_AXI_ACLK,
	input  logic                    M_AXI_ARESETN,
	input  frame_reader_pkg::addr_t araddr,
	input  logic                    arvalid,
	output logic                    arready,
	output frame_reader_pkg::data_t rdata,
	output logic [1:0]              rresp,
	output logic                    rlast,
	output logic                    rvalid,
	input  logic                    rready,
	input  int                      err_beat
);
	import frame_reader_pkg::*;

	localparam data_t DATA_MASK  = 32'h5A5A_0000;
	localparam int    BEAT_BYTES = `FR_DATA_W / 8;

	logic  ar_hs;
	logic  r_hs;
	logic  in_burst;
	addr_t burst_addr;
	int    beat;
	int    beat_no;
	int    gap;

	// Handshakes as the DUT sees them on the rising edge
	always @(posedge M_AXI_ACLK) begin
		ar_hs <= arvalid && arready;
		r_hs  <= rvalid && rready;
	end

	// --------------------
	// Slave outputs change on the falling edge only
	initial begin
		void'($urandom(32'h72d9));
		arready  = 1'b0;
		rvalid   = 1'b0;
		rlast    = 1'b0;
		rresp    = 2'b00;
		rdata    = '0;
		in_burst = 1'b0;
		beat     = 0;
		beat_no  = 0;
		gap      = 0;
		forever begin
			@(negedge M_AXI_ACLK);
			if (!M_AXI_ARESETN) begin
				arready  = 1'b0;
				rvalid   = 1'b0;
				rlast    = 1'b0;
				in_burst = 1'b0;
				beat_no  = 0;
				gap      = 0;
			end else begin
				if (ar_hs) begin
					arready    = 1'b0;
					in_burst   = 1'b1;
					burst_addr = araddr;
					beat       = 0;
					gap        = $urandom_range(3);
				end
				if (r_hs) begin
					// Burst is over once the last beat is taken
					if (rlast)
						in_burst = 1'b0;
					rvalid  = 1'b0;
					rlast   = 1'b0;
					beat    = beat + 1;
					beat_no = beat_no + 1;
					gap     = $urandom_range(3);
				end
				if (gap != 0)
					gap = gap - 1;
				else if (!in_burst && arvalid && !arready)
					arready = 1'b1;
				else if (in_burst && !rvalid) begin
					rdata  = data_t'(burst_addr + addr_t'(beat * BEAT_BYTES)) ^ DATA_MASK;
					rresp  = (beat_no == err_beat) ? 2'b10 : 2'b00;
					rlast  = (beat == `FR_BURST_LEN - 1);
					rvalid = 1'b1;
				end
			end
		end
	end

endmodule

// ==== test/tb_frame_reader.sv ====
`timescale 1ns/1ps
`include "frame_reader_defs.svh"

module tb_frame_reader;
	import frame_reader_pkg::*;

	localparam int       WAIT_LIMIT   = 200;
	localparam int       BEAT_BYTES   = `FR_DATA_W / 8;
	localparam int       LINE_BEATS   = `FR_IMG_WIDTH / BEAT_BYTES;
	localparam int       FRAME_BEATS  = LINE_BEATS * `FR_IMG_HEIGHT;
	localparam int       FRAME_BURSTS = FRAME_BEATS / `FR_BURST_LEN;
	localparam int       BURST_BYTES  = `FR_BURST_LEN * BEAT_BYTES;
	localparam addr_t    BASE_A       = 32'h0001_0000;
	localparam addr_t    BASE_B       = 32'h0002_0400;
	localparam data_t    DATA_MASK    = 32'h5A5A_0000;
	localparam reg_sel_t SEL_CTRL     = 2'd0;
	localparam reg_sel_t SEL_BASE     = 2'd1;
	localparam reg_sel_t SEL_STATUS   = 2'd2;

	logic       M_AXI_ACLK = 1'b0;
	logic       M_AXI_ARESETN;
	logic       cfg_we;
	reg_sel_t   cfg_sel;
	data_t      cfg_wdata;
	data_t      cfg_rdata;
	logic       out_valid;
	data_t      out_data;
	logic       out_sof;
	logic       out_eol;
	logic       out_pop;
	logic       arid;
	addr_t      araddr;
	logic [7:0] arlen;
	logic [2:0] arsize;
	logic [1:0] arburst;
	logic       arlock;
	logic [3:0] arcache;
	logic [2:0] arprot;
	logic [3:0] arqos;
	logic       arvalid;
	logic       arready;
	data_t      rdata;
	logic [1:0] rresp;
	logic       rlast;
	logic       rvalid;
	logic       rready;
	int         err_beat;
	int         frames_done;
	addr_t      ar_seen [$];

	always #5 M_AXI_ACLK = ~M_AXI_ACLK;

	frame_reader_top i_dut (
		.M_AXI_ACLK (M_AXI_ACLK), .M_AXI_ARESETN (M_AXI_ARESETN),
		.cfg_we (cfg_we), .cfg_sel (cfg_sel), .cfg_wdata (cfg_wdata), .cfg_rdata (cfg_rdata),
		.out_valid (out_valid), .out_data (out_data), .out_sof (out_sof),
		.out_eol (out_eol), .out_pop (out_pop),
		.M_AXI_ARID (arid), .M_AXI_ARADDR (araddr), .M_AXI_ARLEN (arlen),
		.M_AXI_ARSIZE (arsize), .M_AXI_ARBURST (arburst), .M_AXI_ARLOCK (arlock),
		.M_AXI_ARCACHE (arcache), .M_AXI_ARPROT (arprot), .M_AXI_ARQOS (arqos),
		.M_AXI_ARVALID (arvalid), .M_AXI_ARREADY (arready),
		.M_AXI_RID (1'b0), .M_AXI_RDATA (rdata), .M_AXI_RRESP (rresp),
		.M_AXI_RLAST (rlast), .M_AXI_RVALID (rvalid), .M_AXI_RREADY (rready)
	);

	axi_rd_mem_model i_mem (
		.M_AXI_ACLK (M_AXI_ACLK), .M_AXI_ARESETN (M_AXI_ARESETN),
		.araddr (araddr), .arvalid (arvalid), .arready (arready),
		.rdata (rdata), .rresp (rresp), .rlast (rlast), .rvalid (rvalid),
		.rready (rready), .err_beat (err_beat)
	);

	// Every accepted read address, in order
	always @(posedge M_AXI_ACLK) begin
		if (arvalid && arready) begin
			ar_seen.push_back(araddr);
			// INCR bursts of four 4-byte beats
			check_field("M_AXI_ARLEN", arlen, 8'(`FR_BURST_LEN - 1));
			check_field("M_AXI_ARSIZE", 8'(arsize), 8'd2);
			check_field("M_AXI_ARBURST", 8'(arburst), 8'd1);
			// Tied-off fields
			check_field("M_AXI_ARID", 8'(arid), 8'd0);
			check_field("M_AXI_ARLOCK", 8'(arlock), 8'd0);
			check_field("M_AXI_ARCACHE", 8'(arcache), 8'd0);
			check_field("M_AXI_ARPROT", 8'(arprot), 8'd0);
			check_field("M_AXI_ARQOS", 8'(arqos), 8'd0);
		end
	end

	// --------------------
	task automatic abort_run(string why);
		$display("Regression failed");
		$fatal(1, why);
	endtask

	task automatic check_data(string name, data_t got, data_t exp);
		if (got !== exp) begin
			$display("Fail at %0t: %s is %h, expected %h", $time, name, got, exp);
			abort_run("data value mismatch");
		end
	endtask

	task automatic check_flag(string name, logic got, logic exp);
		if (got !== exp) begin
			$display("Fail at %0t: %s is %b, expected %b", $time, name, got, exp);
			abort_run("flag value mismatch");
		end
	endtask

	task automatic check_addr(string name, addr_t got, addr_t exp);
		if (got !== exp) begin
			$display("Fail at %0t: %s is %h, expected %h", $time, name, got, exp);
			abort_run("address mismatch");
		end
	endtask

	task automatic check_count(string name, frame_cnt_t got, frame_cnt_t exp);
		if (got !== exp) begin
			$display("Fail at %0t: %s is %0d, expected %0d", $time, name, got, exp);
			abort_run("frame count mismatch");
		end
	endtask

	task automatic check_field(string name, logic [7:0] got, logic [7:0] exp);
		if (got !== exp) begin
			$display("Fail at %0t: %s is %h, expected %h", $time, name, got, exp);
			abort_run("read address field mismatch");
		end
	endtask

	// --------------------
	task automatic write_reg(reg_sel_t sel, data_t val);
		cfg_sel   = sel;
		cfg_wdata = val;
		cfg_we    = 1'b1;
		@(negedge M_AXI_ACLK);
		cfg_we    = 1'b0;
	endtask

	task automatic read_reg(reg_sel_t sel, output data_t v);
		cfg_sel = sel;
		@(negedge M_AXI_ACLK);
		v = cfg_rdata;
	endtask

	task automatic check_status(logic err_exp);
		data_t v;
		read_reg(SEL_STATUS, v);
		check_count("status frame count", frame_cnt_t'(v[`FR_CNT_W-1:0]),
			frame_cnt_t'(frames_done));
		check_flag("status error bit", v[`FR_DATA_W-1], err_exp);
	endtask

	task automatic pop_beat(output data_t d, output logic sof, output logic eol);
		int n;
		n = 0;
		while (!out_valid) begin
			@(negedge M_AXI_ACLK);
			n++;
			if (n > WAIT_LIMIT)
				abort_run("timed out waiting for out_valid");
		end
		d       = out_data;
		sof     = out_sof;
		eol     = out_eol;
		out_pop = 1'b1;
		@(negedge M_AXI_ACLK);
		out_pop = 1'b0;
	endtask

	// One whole frame from base, with an optional register write after beat 3
	task automatic check_frame(addr_t base, logic mid_write, reg_sel_t sel, data_t val);
		data_t d;
		logic  sof;
		logic  eol;
		int    i;
		for (i = 0; i < FRAME_BEATS; i++) begin
			pop_beat(d, sof, eol);
			check_data("out_data", d, data_t'(base + addr_t'(i * BEAT_BYTES)) ^ DATA_MASK);
			check_flag("out_sof", sof, i == 0);
			check_flag("out_eol", eol, (i % LINE_BEATS) == LINE_BEATS - 1);
			if (mid_write && i == 3)
				write_reg(sel, val);
		end
		if (ar_seen.size() < FRAME_BURSTS)
			abort_run("fewer read bursts than the frame needs");
		for (i = 0; i < FRAME_BURSTS; i++)
			check_addr("M_AXI_ARADDR", ar_seen.pop_front(), base + addr_t'(i * BURST_BYTES));
		frames_done++;
	endtask

	// --------------------
	task automatic test_frame_order();
		data_t v;
		check_flag("out_valid", out_valid, 1'b0);
		check_status(1'b0);
		write_reg(SEL_BASE, data_t'(BASE_A));
		write_reg(SEL_CTRL, data_t'(1));
		read_reg(SEL_BASE, v);
		check_addr("base address readback", addr_t'(v), BASE_A);
		read_reg(SEL_CTRL, v);
		check_data("control readback", v, data_t'(1));
		check_frame(BASE_A, 1'b0, SEL_CTRL, '0);
		check_status(1'b0);
	endtask

	task automatic test_back_pressure();
		int n;
		n = 0;
		while (rready) begin
			@(negedge M_AXI_ACLK);
			n++;
			if (n > WAIT_LIMIT)
				abort_run("FIFO never filled with out_pop held low");
		end
		check_flag("out_valid", out_valid, 1'b1);
		check_frame(BASE_A, 1'b0, SEL_CTRL, '0);
		check_status(1'b0);
	endtask

	task automatic test_base_change();
		check_frame(BASE_A, 1'b1, SEL_BASE, data_t'(BASE_B));
		check_frame(BASE_B, 1'b0, SEL_CTRL, '0);
		check_status(1'b0);
	endtask

	task automatic test_error_and_disable();
		// Beat index 6 of the frame after the next one
		err_beat = FRAME_BEATS * (frames_done + 1) + 6;
		check_frame(BASE_B, 1'b0, SEL_CTRL, '0);
		check_frame(BASE_B, 1'b0, SEL_CTRL, '0);
		check_status(1'b1);
		write_reg(SEL_STATUS, '0);
		check_status(1'b0);
		check_frame(BASE_B, 1'b1, SEL_CTRL, '0);
		repeat (40) begin
			@(negedge M_AXI_ACLK);
			check_flag("M_AXI_ARVALID", arvalid, 1'b0);
		end
		if (ar_seen.size() != 0)
			abort_run("read burst issued after enable was cleared");
		check_status(1'b0);
	endtask

	initial begin
		M_AXI_ARESETN = 1'b0;
		cfg_we        = 1'b0;
		cfg_sel       = SEL_CTRL;
		cfg_wdata     = '0;
		out_pop       = 1'b0;
		err_beat      = -1;
		frames_done   = 0;
		repeat (4) @(negedge M_AXI_ACLK);
		M_AXI_ARESETN = 1'b1;
		test_frame_order();
		test_back_pressure();
		test_base_change();
		test_error_and_disable();
		$display("Regression passed");
		$finish;
	end

endmodule

// ==== tb.f ====
+incdir+include
source/frame_reader_pkg.sv
source/rd_ctrl_if.sv
source/reader_regs.sv
source/burst_reader.sv
source/frame_tracker.sv
source/beat_fifo.sv
source/frame_reader_top.sv
test/axi_rd_mem_model.sv
test/tb_frame_reader.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the frame reader regression with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing -j 0 \
	--top-module tb_frame_reader \
	-f tb.f

./obj_dir/Vtb_frame_reader
